// File: filelist.f
logic/ema_pkg.sv
logic/shift.sv
logic/ema_control.sv
logic/ema_error.sv
logic/ema_accum.sv
logic/ema_filter.sv
testbench/ema_filter_tb.sv

// File: logic/ema_accum.sv
`timescale 1ns/10ps

// scaled running average and its narrowed output.
module ema_accum (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       update,
    input  logic                       load,
    input  logic [ema_pkg::err_w-1:0]  err,
    input  logic [ema_pkg::err_w-1:0]  err_shifted,
    output logic [ema_pkg::acc_w-1:0]  acc,
    output logic [ema_pkg::data_w-1:0] dout
);

    // accumulator with the guard bits dropped, still acc_w wide.
    logic [ema_pkg::acc_w-1:0] acc_narrow;

    // ------------------------------------------------------------
    // accumulator
    // ------------------------------------------------------------

    // on load err is scaled sample minus acc, so acc becomes the sample.
    // the sum always lies between two in-range values, so the
    // truncation to acc_w is exact.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end
        else if (load) begin
            acc <= acc + err[ema_pkg::acc_w-1:0];
        end
        else if (update) begin
            acc <= acc + err_shifted[ema_pkg::acc_w-1:0];
        end
    end

    // ------------------------------------------------------------
    // output narrowing
    // ------------------------------------------------------------

    shift #(
        .data_width  (ema_pkg::acc_w),
        .data_type   ("signed"),
        .shift_value (-ema_pkg::guard_bits),
        .async       (1'b1)
    ) narrow_inst (
        .clk  (clk),
        .din  (acc),
        .dout (acc_narrow)
    );

    // upper bits only repeat the sign.
    assign dout = acc_narrow[ema_pkg::data_w-1:0];

endmodule

// File: logic/ema_control.sv
`timescale 1ns/10ps

// sequences one sample through the datapath in three edges.
// stage 0 is idle, stage 1 waits for the registered shift,
// stage 2 applies the result to the accumulator.
module ema_control (
    input  logic clk,
    input  logic rst,
    input  logic din_valid,
    input  logic clear,
    output logic busy,
    output logic capture,
    output logic update,
    output logic load,
    output logic dout_valid
);

    // position of the sample in flight, zero when idle.
    logic [1:0] stage;

    // set while the next accepted sample must be loaded directly.
    logic preload;

    // load or update choice made for the sample in flight.
    logic mode_load;

    // ------------------------------------------------------------
    // acceptance
    // ------------------------------------------------------------

    // strobes that arrive while busy are dropped.
    assign busy    = (stage != 2'd0);
    assign capture = din_valid & ~busy;

    // ------------------------------------------------------------
    // stage counter and strobes
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            stage      <= 2'd0;
            preload    <= 1'b1;
            mode_load  <= 1'b0;
            load       <= 1'b0;
            update     <= 1'b0;
            dout_valid <= 1'b0;
        end
        else begin
            case (stage)
                2'd0: begin
                    if (capture) begin
                        stage <= 2'd1;
                    end
                end
                2'd1: begin
                    stage <= 2'd2;
                end
                default: begin
                    stage <= 2'd0;
                end
            endcase

            // the choice is fixed when the sample is accepted.
            if (capture) begin
                mode_load <= preload;
            end

            // clear wins over a preload being consumed on the same edge.
            if (clear) begin
                preload <= 1'b1;
            end
            else if (capture) begin
                preload <= 1'b0;
            end

            // apply strobes are high in the cycle before the third edge.
            load       <= (stage == 2'd1) & mode_load;
            update     <= (stage == 2'd1) & ~mode_load;
            dout_valid <= (stage == 2'd2);
        end
    end

endmodule

// File: logic/ema_error.sv
`timescale 1ns/10ps

// difference between the scaled new sample and the accumulator.
module ema_error (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       capture,
    input  logic [ema_pkg::data_w-1:0] din,
    input  logic [ema_pkg::acc_w-1:0]  acc,
    output logic [ema_pkg::err_w-1:0]  err
);

    // sample sign extended to the accumulator width.
    logic [ema_pkg::acc_w-1:0] din_ext;

    // sample moved up by the guard bits.
    logic [ema_pkg::acc_w-1:0] din_scaled;

    assign din_ext = {{ema_pkg::guard_bits{din[ema_pkg::data_w-1]}}, din};

    shift #(
        .data_width  (ema_pkg::acc_w),
        .data_type   ("signed"),
        .shift_value (ema_pkg::guard_bits),
        .async       (1'b1)
    ) scale_inst (
        .clk  (clk),
        .din  (din_ext),
        .dout (din_scaled)
    );

    // held between captures so the load path can reuse it.
    always_ff @(posedge clk) begin
        if (rst) begin
            err <= '0;
        end
        else if (capture) begin
            err <= {din_scaled[ema_pkg::acc_w-1], din_scaled}
                 - {acc[ema_pkg::acc_w-1], acc};
        end
    end

endmodule

// File: logic/ema_filter.sv
`timescale 1ns/10ps

// exponential moving average, one sample every three cycles.
module ema_filter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [ema_pkg::data_w-1:0] din,
    input  logic                       din_valid,
    input  logic                       clear,
    output logic                       busy,
    output logic [ema_pkg::data_w-1:0] dout,
    output logic                       dout_valid
);

    logic                      capture;
    logic                      update;
    logic                      load;
    logic [ema_pkg::err_w-1:0] err;
    logic [ema_pkg::err_w-1:0] err_shifted;
    logic [ema_pkg::acc_w-1:0] acc;

    ema_control ema_control_inst (
        .clk        (clk),
        .rst        (rst),
        .din_valid  (din_valid),
        .clear      (clear),
        .busy       (busy),
        .capture    (capture),
        .update     (update),
        .load       (load),
        .dout_valid (dout_valid)
    );

    ema_error ema_error_inst (
        .clk     (clk),
        .rst     (rst),
        .capture (capture),
        .din     (din),
        .acc     (acc),
        .err     (err)
    );

    // alpha weighting, registered to give the second pipeline edge.
    shift #(
        .data_width  (ema_pkg::err_w),
        .data_type   ("signed"),
        .shift_value (-ema_pkg::alpha_shift),
        .async       (1'b0)
    ) alpha_inst (
        .clk  (clk),
        .din  (err),
        .dout (err_shifted)
    );

    ema_accum ema_accum_inst (
        .clk         (clk),
        .rst         (rst),
        .update      (update),
        .load        (load),
        .err         (err),
        .err_shifted (err_shifted),
        .acc         (acc),
        .dout        (dout)
    );

endmodule

// File: logic/ema_pkg.sv
package ema_pkg;

    // ------------------------------------------------------------
    // sample and accumulator widths
    // ------------------------------------------------------------

    // width of the input samples and of the filtered output.
    localparam int data_w = 16;

    // fractional bits carried below the sample lsb in the accumulator.
    localparam int guard_bits = 4;

    // scaled accumulator, one sample shifted left by guard_bits.
    localparam int acc_w = data_w + guard_bits;

    // one extra bit so scaled sample minus accumulator never overflows.
    localparam int err_w = acc_w + 1;

    // ------------------------------------------------------------
    // filter coefficient
    // ------------------------------------------------------------

    // alpha = 2**-alpha_shift, here 1/8.
    localparam int alpha_shift = 3;

endpackage

// File: logic/shift.sv
`timescale 1ns/10ps

// constant shift by shift_value bits.
// a positive value shifts left, a negative value shifts right.
// signed data uses arithmetic shifts, unsigned data logical ones.
// async set gives a combinational path, cleared gives one register.
module shift #(
    parameter int data_width  = 16,
    parameter     data_type   = "signed",
    parameter int shift_value = -1,
    parameter bit async       = 1'b0
) (
    input  logic                  clk,
    input  logic [data_width-1:0] din,
    output logic [data_width-1:0] dout
);

    // shifted value before the optional output register.
    logic [data_width-1:0] shifted;

    // ------------------------------------------------------------
    // shift operator
    // ------------------------------------------------------------

    generate
        if (data_type == "signed") begin : g_signed
            if (shift_value > 0) begin : g_left
                assign shifted = $signed(din) <<< shift_value;
            end
            else if (shift_value < 0) begin : g_right
                // arithmetic right shift floors toward minus infinity.
                assign shifted = $signed(din) >>> (-shift_value);
            end
            else begin : g_none
                assign shifted = din;
            end
        end
        else begin : g_unsigned
            if (shift_value > 0) begin : g_left
                assign shifted = din << shift_value;
            end
            else if (shift_value < 0) begin : g_right
                assign shifted = din >> (-shift_value);
            end
            else begin : g_none
                assign shifted = din;
            end
        end
    endgenerate

    // ------------------------------------------------------------
    // output stage
    // ------------------------------------------------------------

    generate
        if (async) begin : g_comb
            assign dout = shifted;
        end
        else begin : g_reg
            logic [data_width-1:0] dout_q;

            always_ff @(posedge clk) begin
                dout_q <= shifted;
            end

            assign dout = dout_q;
        end
    endgenerate

endmodule

// File: testbench/ema_filter_tb.sv
`timescale 1ns/10ps

module ema_filter_tb;

    localparam int clk_period = 20;
    localparam int n_const    = 80;
    localparam int n_random   = 200;

    // each sample needs at most eight cycles including gaps and extra strobes.
    localparam int stim_cycles = 8 + 60 + (n_const + n_random + 8) * 8;
    localparam int cycle_limit = 3 * stim_cycles + 100;

    logic                       clk;
    logic                       rst;
    logic [ema_pkg::data_w-1:0] din;
    logic                       din_valid;
    logic                       clear;
    logic                       busy;
    logic [ema_pkg::data_w-1:0] dout;
    logic                       dout_valid;

    // reference model of the scaled accumulator and the preload flag.
    int  model_acc;
    int  model_x;
    int  model_out;
    int  scaled;
    bit  model_preload;
    bit  model_load;
    bit  accept;

    // expected outputs trail the model update by one cycle.
    logic [1:0]                 exp_stage;
    logic                       exp_dv;
    logic                       exp_was_load;
    logic [ema_pkg::data_w-1:0] exp_dout;
    logic [ema_pkg::data_w-1:0] exp_sample;

    // samples handed over by the stimulus and outputs seen from the DUT.
    int accepted = 0;
    int produced;
    int cycle_count = 0;
    int i;
    int sel;
    logic [ema_pkg::data_w-1:0] x;

    ema_filter ema_filter_inst (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .clear      (clear),
        .busy       (busy),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            exp_stage     <= 2'd0;
            exp_dv        <= 1'b0;
            exp_was_load  <= 1'b0;
            exp_dout      <= '0;
            exp_sample    <= '0;
            model_acc     = 0;
            model_x       = 0;
            model_preload = 1'b1;
            model_load    = 1'b0;
            produced      = 0;
        end
        else begin
            accept = din_valid && (exp_stage == 2'd0);
            if (accept) begin
                model_x    = $signed(din);
                model_load = model_preload;
            end
            if (clear) begin
                model_preload = 1'b1;
            end
            else if (accept) begin
                model_preload = 1'b0;
            end
            if (dout_valid) begin
                produced++;
            end
            case (exp_stage)
                2'd0: exp_stage <= accept ? 2'd1 : 2'd0;
                2'd1: exp_stage <= 2'd2;
                default: exp_stage <= 2'd0;
            endcase
            exp_dv <= (exp_stage == 2'd2);
            // the new average adds floor((x * 2**guard - acc) / 2**alpha) to acc.
            if (exp_stage == 2'd2) begin
                scaled = model_x * (1 << ema_pkg::guard_bits);
                if (model_load) begin
                    model_acc = scaled;
                end
                else begin
                    model_acc = model_acc + ((scaled - model_acc) >>> ema_pkg::alpha_shift);
                end
                model_out    = model_acc >>> ema_pkg::guard_bits;
                exp_dout     <= model_out[ema_pkg::data_w-1:0];
                exp_was_load <= model_load;
                exp_sample   <= model_x[ema_pkg::data_w-1:0];
            end
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    a_busy: assert property (@(posedge clk) disable iff (rst) busy == (exp_stage != 2'd0))
        else report_mismatch($sformatf("busy is %b, expected %b",
                                       $sampled(busy), $sampled(exp_stage) != 2'd0));

    a_valid: assert property (@(posedge clk) disable iff (rst) dout_valid == exp_dv)
        else report_mismatch($sformatf("dout_valid is %b, expected %b",
                                       $sampled(dout_valid), $sampled(exp_dv)));

    a_dout: assert property (@(posedge clk) disable iff (rst) dout_valid |-> dout == exp_dout)
        else report_mismatch($sformatf("dout is %h, expected %h",
                                       $sampled(dout), $sampled(exp_dout)));

    // a preloaded output is the sample itself.
    a_preload: assert property (@(posedge clk) disable iff (rst)
        (dout_valid && exp_was_load) |-> dout == exp_sample)
        else report_mismatch($sformatf("preload dout is %h, expected %h",
                                       $sampled(dout), $sampled(exp_sample)));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // waits for the filter to go idle and strobes one sample.
    task automatic issue(input logic [ema_pkg::data_w-1:0] value);
        while (busy) begin
            idle(1);
        end
        din       = value;
        din_valid = 1'b1;
        idle(1);
        din_valid = 1'b0;
        accepted++;
    endtask

    task automatic strobe_while_busy(input logic [ema_pkg::data_w-1:0] value);
        din       = value;
        din_valid = 1'b1;
        idle(1);
        din_valid = 1'b0;
    endtask

    task automatic pulse_clear();
        clear = 1'b1;
        idle(1);
        clear = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h27700e9f));
        rst       = 1'b1;
        din       = '0;
        din_valid = 1'b0;
        clear     = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        idle(6);

        // full scale samples that each take the preload path.
        issue(16'h7fff);
        idle(4);
        pulse_clear();
        issue(16'h8000);
        idle(4);

        // constant input from zero converges and then holds.
        pulse_clear();
        issue(16'h0000);
        for (i = 0; i < n_const; i++) begin
            issue(16'd1000);
        end

        pulse_clear();
        for (i = 0; i < n_random; i++) begin
            sel = $urandom_range(0, 15);
            if (sel == 0) begin
                x = 16'h7fff;
            end
            else if (sel == 1) begin
                x = 16'h8000;
            end
            else begin
                x = $urandom();
            end
            issue(x);
            // strobe lands on a busy edge and is dropped.
            if (sel[2]) begin
                strobe_while_busy($urandom());
            end
            idle($urandom_range(0, 3));
        end

        // clear lands one edge after acceptance and the sample after it is a preload.
        issue(16'h1234);
        pulse_clear();
        issue(16'hedcb);
        issue(16'h0100);
        idle(8);

        a_count: assert (accepted == produced)
            else report_mismatch($sformatf("%0d samples accepted, %0d outputs seen",
                                           accepted, produced));
        $display("Finished with no errors");
        $finish;
    end

endmodule
